//--- common/rv_pkg.sv
// rv64 subset encodings only, machine mode only, no compressed instructions and no misa reporting
package rv_pkg;

    localparam int XLEN = 64;                        // data and address width
    localparam int ILEN = 32;                        // fixed instruction length

    typedef logic [XLEN-1:0] xlen_t;                 // data word or byte address
    typedef logic [ILEN-1:0] inst_t;                 // raw instruction word
    typedef logic [4:0]      reg_idx_t;              // x0..x31
    typedef logic [11:0]     csr_addr_t;             // csr number from inst[31:20]
    typedef logic [1:0]      csr_op_t;               // what the csr block does this cycle

    // csr operation codes on the csr bus
    localparam csr_op_t CSR_NONE  = 2'd0;
    localparam csr_op_t CSR_WRITE = 2'd1;            // csrrw
    localparam csr_op_t CSR_SET   = 2'd2;            // csrrs
    localparam csr_op_t CSR_CLEAR = 2'd3;            // csrrc

    // major opcodes, inst[6:0]
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_IMM    = 7'b0010011;   // addi xori ori andi
    localparam logic [6:0] OP_REG    = 7'b0110011;   // add sub
    localparam logic [6:0] OP_BRANCH = 7'b1100011;   // beq bne
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;   // ld only
    localparam logic [6:0] OP_STORE  = 7'b0100011;   // sd only
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;   // csr ops, ecall, mret

    // machine csrs that exist, everything else reads zero
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;

    // ecall from m mode, interrupt bit clear
    localparam xlen_t CAUSE_ECALL_M = 64'd11;

    // addi x0,x0,0 held in the instruction register out of reset
    localparam inst_t NOP_INST = 32'h0000_0013;

endpackage

//--- common/fetch_exec_if.sv
// no handshake between stages, a redirect is taken at the very next clock edge
`timescale 1ns/1ps

interface fetch_exec_if;

    // fetch -> execute
    logic          valid;        // low in the flushed slot and out of reset
    rv_pkg::inst_t inst;         // instruction register
    rv_pkg::xlen_t pc;           // address of inst

    // execute -> fetch
    logic          redirect;     // one cycle pulse, taken branch, jal, ecall or mret
    rv_pkg::xlen_t redirect_pc;  // new fetch address

    modport fetch (output valid, inst, pc, input redirect, redirect_pc);

    modport exec (input valid, inst, pc, output redirect, redirect_pc);

endinterface

//--- common/csr_bus_if.sv
// op and trap are never high together, reads are combinational, updates land at the edge
`timescale 1ns/1ps

interface csr_bus_if;

    // execute -> csr block
    rv_pkg::csr_op_t   op;          // CSR_NONE when idle
    rv_pkg::csr_addr_t addr;        // inst[31:20]
    rv_pkg::xlen_t     wdata;       // rs1 value
    logic              trap;        // ecall in execute this cycle
    rv_pkg::xlen_t     epc;         // pc of the ecall

    // csr block -> execute
    rv_pkg::xlen_t     rdata;       // old csr value, goes to rd
    rv_pkg::xlen_t     mtvec_base;  // direct mode only
    rv_pkg::xlen_t     mepc_val;    // mret target

    modport exec (output op, addr, wdata, trap, epc,
                  input rdata, mtvec_base, mepc_val);

    modport csr (input op, addr, wdata, trap, epc,
                 output rdata, mtvec_base, mepc_val);

endinterface

//--- rtl/fetch_stage.sv
// imem must answer combinationally in the same cycle, RESET_PC must be word aligned
`timescale 1ns/1ps

module fetch_stage #(
    parameter rv_pkg::xlen_t RESET_PC = '0
) (
    input  logic          clk_1hz,
    input  logic          reset_n,
    output rv_pkg::xlen_t o_imem_addr,
    input  rv_pkg::inst_t i_imem_data,
    fetch_exec_if.fetch   fe
);

    rv_pkg::xlen_t pc;       // address currently on the imem port
    rv_pkg::xlen_t pc_next;

    assign o_imem_addr = pc;

    // a redirect wins over sequential fetch
    assign pc_next = fe.redirect ? fe.redirect_pc : pc + 64'd4;

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // instruction register and its pc, handed to execute next cycle
    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            fe.inst  <= rv_pkg::NOP_INST;
            fe.pc    <= '0;
            fe.valid <= 1'b0;
        end else begin
            fe.inst  <= i_imem_data;
            fe.pc    <= pc;
            // word fetched alongside a redirect is the wrong path, drop it
            fe.valid <= ~fe.redirect;
        end
    end

endmodule

//--- execute/reg_file.sv
// asynchronous reads, x0 always reads zero, a write and a read of the same register gives the old value
`timescale 1ns/1ps

module reg_file (
    input  logic             clk_1hz,
    input  logic             reset_n,
    input  rv_pkg::reg_idx_t i_rs1,
    input  rv_pkg::reg_idx_t i_rs2,
    output rv_pkg::xlen_t    o_rs1_data,
    output rv_pkg::xlen_t    o_rs2_data,
    input  logic             i_we,
    input  rv_pkg::reg_idx_t i_rd,
    input  rv_pkg::xlen_t    i_rd_data
);

    rv_pkg::xlen_t regs [0:31];   // x0 slot is never written after reset

    // x0 forced to zero on both read ports
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin   // writes to x0 dropped
            regs[i_rd] <= i_rd_data;
        end
    end

endmodule

//--- execute/execute_stage.sv
// one instruction per cycle, dmem reads are combinational, unsupported encodings act as nops
`timescale 1ns/1ps

module execute_stage (
    input  logic          clk_1hz,
    input  logic          reset_n,
    fetch_exec_if.exec    fe,
    csr_bus_if.exec       cb,
    output rv_pkg::xlen_t o_dmem_addr,
    output rv_pkg::xlen_t o_dmem_wdata,
    output logic          o_dmem_we,
    input  rv_pkg::xlen_t i_dmem_rdata
);

    localparam logic [2:0]  F3_ADD   = 3'b000;    // addi, add, sub
    localparam logic [2:0]  F3_XOR   = 3'b100;
    localparam logic [2:0]  F3_OR    = 3'b110;
    localparam logic [2:0]  F3_AND   = 3'b111;
    localparam logic [2:0]  F3_BEQ   = 3'b000;
    localparam logic [2:0]  F3_BNE   = 3'b001;
    localparam logic [2:0]  F3_DW    = 3'b011;    // ld / sd width
    localparam logic [2:0]  F3_PRIV  = 3'b000;    // ecall, mret
    localparam logic [2:0]  F3_CSRRW = 3'b001;
    localparam logic [2:0]  F3_CSRRS = 3'b010;
    localparam logic [2:0]  F3_CSRRC = 3'b011;
    localparam logic [6:0]  F7_ADD   = 7'b0000000;
    localparam logic [6:0]  F7_SUB   = 7'b0100000;
    localparam logic [11:0] F12_ECALL = 12'h000;
    localparam logic [11:0] F12_MRET  = 12'h302;

    logic [6:0]        opcode;
    logic [2:0]        f3;
    logic [6:0]        f7;
    rv_pkg::csr_addr_t f12;                        // funct12 or csr number
    rv_pkg::reg_idx_t  rd, rs1, rs2;
    rv_pkg::xlen_t     imm_i, imm_s, imm_b, imm_u, imm_j;
    rv_pkg::xlen_t     rs1_data, rs2_data, rd_data, alu_imm, link_pc;
    logic              rd_we, imm_ok, reg_ok, is_jal, is_load, is_store;
    logic              is_csr, is_ecall, is_mret, br_taken;

    // field split
    assign opcode = fe.inst[6:0];
    assign rd     = fe.inst[11:7];
    assign f3     = fe.inst[14:12];
    assign rs1    = fe.inst[19:15];
    assign rs2    = fe.inst[24:20];
    assign f7     = fe.inst[31:25];
    assign f12    = fe.inst[31:20];

    // immediates, all sign extended to 64 bits
    assign imm_i = {{52{fe.inst[31]}}, fe.inst[31:20]};
    assign imm_s = {{52{fe.inst[31]}}, fe.inst[31:25], fe.inst[11:7]};
    assign imm_b = {{52{fe.inst[31]}}, fe.inst[7], fe.inst[30:25], fe.inst[11:8], 1'b0};
    assign imm_u = {{32{fe.inst[31]}}, fe.inst[31:12], 12'b0};
    assign imm_j = {{44{fe.inst[31]}}, fe.inst[19:12], fe.inst[20], fe.inst[30:21], 1'b0};

    reg_file u_regs (
        .clk_1hz    (clk_1hz),
        .reset_n    (reset_n),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_we       (rd_we),
        .i_rd       (rd),
        .i_rd_data  (rd_data)
    );

    // decode of the kept subset
    assign imm_ok   = (opcode == rv_pkg::OP_IMM) && (f3 inside {F3_ADD, F3_XOR, F3_OR, F3_AND});
    assign reg_ok   = (opcode == rv_pkg::OP_REG) && (f3 == F3_ADD) && (f7 inside {F7_ADD, F7_SUB});
    assign is_jal   = (opcode == rv_pkg::OP_JAL);
    assign is_load  = (opcode == rv_pkg::OP_LOAD) && (f3 == F3_DW);
    assign is_store = (opcode == rv_pkg::OP_STORE) && (f3 == F3_DW);
    assign is_csr   = (opcode == rv_pkg::OP_SYSTEM) && (f3 inside {F3_CSRRW, F3_CSRRS, F3_CSRRC});
    assign is_ecall = (opcode == rv_pkg::OP_SYSTEM) && (f3 == F3_PRIV) && (f12 == F12_ECALL);
    assign is_mret  = (opcode == rv_pkg::OP_SYSTEM) && (f3 == F3_PRIV) && (f12 == F12_MRET);
    assign br_taken = (opcode == rv_pkg::OP_BRANCH)
                    && (((f3 == F3_BEQ) && (rs1_data == rs2_data))
                     || ((f3 == F3_BNE) && (rs1_data != rs2_data)));

    assign link_pc = fe.pc + 64'd4;   // jal return address

    always_comb begin
        case (f3)
            F3_XOR:  alu_imm = rs1_data ^ imm_i;
            F3_OR:   alu_imm = rs1_data | imm_i;
            F3_AND:  alu_imm = rs1_data & imm_i;
            default: alu_imm = rs1_data + imm_i;   // addi
        endcase
    end

    // writeback value, qualified by rd_we below
    always_comb begin
        case (opcode)
            rv_pkg::OP_LUI:    rd_data = imm_u;
            rv_pkg::OP_AUIPC:  rd_data = fe.pc + imm_u;
            rv_pkg::OP_IMM:    rd_data = alu_imm;
            rv_pkg::OP_REG:    rd_data = (f7 == F7_SUB) ? rs1_data - rs2_data : rs1_data + rs2_data;
            rv_pkg::OP_JAL:    rd_data = link_pc;
            rv_pkg::OP_LOAD:   rd_data = i_dmem_rdata;   // sampled this same cycle
            rv_pkg::OP_SYSTEM: rd_data = cb.rdata;       // old csr value
            default:           rd_data = '0;
        endcase
    end

    assign rd_we = fe.valid && ((opcode == rv_pkg::OP_LUI) || (opcode == rv_pkg::OP_AUIPC)
                 || imm_ok || reg_ok || is_jal || is_load || is_csr);

    // data port, one adder shared by ld and sd
    assign o_dmem_addr  = rs1_data + (is_store ? imm_s : imm_i);
    assign o_dmem_wdata = rs2_data;
    assign o_dmem_we    = fe.valid && is_store;

    // csr bus
    always_comb begin
        cb.op = rv_pkg::CSR_NONE;
        if (fe.valid && is_csr) begin
            case (f3)
                F3_CSRRW: cb.op = rv_pkg::CSR_WRITE;
                F3_CSRRS: cb.op = rv_pkg::CSR_SET;
                default:  cb.op = rv_pkg::CSR_CLEAR;
            endcase
        end
    end
    assign cb.addr  = f12;
    assign cb.wdata = rs1_data;
    assign cb.trap  = fe.valid && is_ecall;
    assign cb.epc   = fe.pc;                 // ecall itself, handler adds 4

    // redirects, each costs exactly one flushed slot in fetch
    assign fe.redirect = fe.valid && (br_taken || is_jal || is_ecall || is_mret);

    always_comb begin
        if (is_ecall) begin
            fe.redirect_pc = cb.mtvec_base;
        end else if (is_mret) begin
            fe.redirect_pc = cb.mepc_val;
        end else if (is_jal) begin
            fe.redirect_pc = fe.pc + imm_j;
        end else begin
            fe.redirect_pc = fe.pc + imm_b;  // branch target
        end
    end

endmodule

//--- rtl/csr_file.sv
// only mscratch mtvec mepc mcause exist, mtvec is direct mode, no privilege or access checks
`timescale 1ns/1ps

module csr_file (
    input  logic    clk_1hz,
    input  logic    reset_n,
    csr_bus_if.csr  cb
);

    rv_pkg::xlen_t mscratch;
    rv_pkg::xlen_t mtvec;
    rv_pkg::xlen_t mepc;
    rv_pkg::xlen_t mcause;

    rv_pkg::xlen_t old_val;   // addressed register before the op
    rv_pkg::xlen_t new_val;   // value written back
    logic          csr_we;

    // combinational read, unknown address reads zero
    always_comb begin
        case (cb.addr)
            rv_pkg::CSR_MSCRATCH: old_val = mscratch;
            rv_pkg::CSR_MTVEC:    old_val = mtvec;
            rv_pkg::CSR_MEPC:     old_val = mepc;
            rv_pkg::CSR_MCAUSE:   old_val = mcause;
            default:              old_val = '0;
        endcase
    end

    // read-modify-write value for csrrw / csrrs / csrrc
    always_comb begin
        case (cb.op)
            rv_pkg::CSR_WRITE: new_val = cb.wdata;
            rv_pkg::CSR_SET:   new_val = old_val | cb.wdata;
            rv_pkg::CSR_CLEAR: new_val = old_val & ~cb.wdata;
            default:           new_val = old_val;
        endcase
    end

    assign csr_we = (cb.op != rv_pkg::CSR_NONE);

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            mscratch <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (cb.trap) begin
            // ecall entry, always from m mode
            mepc   <= cb.epc;
            mcause <= rv_pkg::CAUSE_ECALL_M;
        end else if (csr_we) begin
            case (cb.addr)
                rv_pkg::CSR_MSCRATCH: mscratch <= new_val;
                rv_pkg::CSR_MTVEC:    mtvec    <= new_val;
                rv_pkg::CSR_MEPC:     mepc     <= new_val;
                rv_pkg::CSR_MCAUSE:   mcause   <= new_val;
                default: ;                              // unknown csr, write ignored
            endcase
        end
    end

    assign cb.rdata      = old_val;
    assign cb.mtvec_base = {mtvec[63:2], 2'b00};    // mode bits ignored
    assign cb.mepc_val   = mepc;

endmodule

//--- rtl/cpu_top.sv
// memories sit outside and never stall, instruction and data reads must be combinational
`timescale 1ns/1ps

module cpu_top #(
    parameter rv_pkg::xlen_t RESET_PC = '0           // word aligned boot address
) (
    input  logic          clk_1hz,
    input  logic          reset_n,
    output rv_pkg::xlen_t o_imem_addr,
    input  rv_pkg::inst_t i_imem_data,
    output rv_pkg::xlen_t o_dmem_addr,
    output rv_pkg::xlen_t o_dmem_wdata,
    output logic          o_dmem_we,
    input  rv_pkg::xlen_t i_dmem_rdata
);

    fetch_exec_if fe_if ();   // stage to stage
    csr_bus_if    cb_if ();   // execute to csr block

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk_1hz     (clk_1hz),
        .reset_n     (reset_n),
        .o_imem_addr (o_imem_addr),
        .i_imem_data (i_imem_data),
        .fe          (fe_if.fetch)
    );

    execute_stage u_exec (
        .clk_1hz      (clk_1hz),
        .reset_n      (reset_n),
        .fe           (fe_if.exec),
        .cb           (cb_if.exec),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_we    (o_dmem_we),
        .i_dmem_rdata (i_dmem_rdata)
    );

    csr_file u_csr (
        .clk_1hz (clk_1hz),
        .reset_n (reset_n),
        .cb      (cb_if.csr)
    );

endmodule

//--- testbench/cpu_assertions.sv
// checks only the top-level fetch address and store strobe, nothing inside the pipeline
`timescale 1ns/1ps

module cpu_assertions (
    input logic          clk_1hz,
    input logic          reset_n,
    input rv_pkg::xlen_t o_imem_addr,
    input logic          o_dmem_we
);

    int unsigned fails = 0;   // read by the testbench at the end of the run

    // pc only moves in steps of 4 or to aligned targets
    imem_aligned: assert property (@(posedge clk_1hz) disable iff (!reset_n)
        o_imem_addr[1:0] == 2'b00)
        else begin $error("imem address not word aligned"); fails++; end

    dmem_we_known: assert property (@(posedge clk_1hz) disable iff (!reset_n)
        !$isunknown(o_dmem_we))
        else begin $error("dmem write enable unknown"); fails++; end

    // valid is cleared in reset, so no store may leak out
    dmem_we_reset: assert property (@(posedge clk_1hz) !reset_n |-> !o_dmem_we)
        else begin $error("dmem write enable high in reset"); fails++; end

endmodule

bind cpu_top cpu_assertions u_cpu_assertions (
    .clk_1hz     (clk_1hz),
    .reset_n     (reset_n),
    .o_imem_addr (o_imem_addr),
    .o_dmem_we   (o_dmem_we)
);

//--- testbench/tb_cpu_top.sv
// reset pc is zero, imem holds 256 words, dmem 4 KiB, every result store goes to 0x800
`timescale 1ns/1ps

module tb_cpu_top;

    localparam rv_pkg::xlen_t RESET_PC    = 64'h0;
    localparam rv_pkg::xlen_t RESULT_ADDR = 64'h800;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int PROG_WORDS   = 32;                  // longest program, with margin
    localparam int N_TESTS      = 6;
    localparam int WAIT_CYCLES  = PROG_WORDS * 3;      // per test budget
    localparam int LIMIT_CYCLES = N_TESTS * (WAIT_CYCLES + RESET_CYCLES + 4);

    logic          clk_1hz;
    logic          reset_n;
    rv_pkg::xlen_t o_imem_addr, o_dmem_addr, o_dmem_wdata, i_dmem_rdata;
    rv_pkg::inst_t i_imem_data;
    logic          o_dmem_we;

    rv_pkg::inst_t imem [0:255];
    rv_pkg::xlen_t dmem [0:511];
    rv_pkg::inst_t prog [$];                           // program being built
    rv_pkg::xlen_t expect_q [$];                       // expected result stores, in order
    rv_pkg::xlen_t store_q [$];                        // stores seen at RESULT_ADDR
    logic [31:0]   lfsr_state = 32'h5a2c25a9;
    int            pass_count = 0;
    int            fail_count = 0;

    cpu_top #(.RESET_PC(RESET_PC)) DUT (
        .clk_1hz      (clk_1hz),
        .reset_n      (reset_n),
        .o_imem_addr  (o_imem_addr),
        .i_imem_data  (i_imem_data),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_we    (o_dmem_we),
        .i_dmem_rdata (i_dmem_rdata)
    );

    // both memories answer in the same cycle
    assign i_imem_data  = imem[o_imem_addr[9:2]];
    assign i_dmem_rdata = dmem[o_dmem_addr[11:3]];

    initial begin
        clk_1hz = 1'b0;
        forever #(CLK_PERIOD / 2) clk_1hz = ~clk_1hz;
    end

    always @(posedge clk_1hz) begin
        if (reset_n && o_dmem_we) begin
            dmem[o_dmem_addr[11:3]] <= o_dmem_wdata;
            if (o_dmem_addr == RESULT_ADDR) begin
                store_q.push_back(o_dmem_wdata);      // result stream
            end
        end
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    // galois lfsr, x^32+x^22+x^2+x+1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
        end
        return val;
    endfunction

    function automatic rv_pkg::xlen_t sx12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic rv_pkg::xlen_t upper(input logic [19:0] v);   // lui value
        return {{32{v[19]}}, v, 12'h000};
    endfunction

    function automatic rv_pkg::xlen_t fill_word(input rv_pkg::xlen_t addr);
        return {~addr[31:0], addr[31:0]};
    endfunction

    // instruction encoders
    function automatic rv_pkg::inst_t enc_u(input logic [6:0] op, input logic [4:0] rd,
                                            input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic rv_pkg::inst_t enc_i(input logic [6:0] op, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::inst_t enc_r(input logic [6:0] f7, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2);
        return {f7, rs2, rs1, 3'b000, rd, rv_pkg::OP_REG};
    endfunction

    function automatic rv_pkg::inst_t enc_s(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], rv_pkg::OP_STORE};   // sd
    endfunction

    function automatic rv_pkg::inst_t enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [12:0] o);
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], rv_pkg::OP_BRANCH};
    endfunction

    function automatic rv_pkg::inst_t enc_j(input logic [4:0] rd, input logic [20:0] o);
        return {o[20], o[10:1], o[11], o[19:12], rd, rv_pkg::OP_JAL};
    endfunction

    function automatic void emit(input rv_pkg::inst_t w);
        prog.push_back(w);
    endfunction

    function automatic rv_pkg::xlen_t pc_now();
        return RESET_PC + 64'(4 * prog.size());
    endfunction

    // sd rs,0(x31) plus its expected value
    function automatic void store_result(input logic [4:0] rs, input rv_pkg::xlen_t exp);
        emit(enc_s(rs, 5'd31, 12'd0));
        expect_q.push_back(exp);
    endfunction

    function automatic void start_program();
        prog.delete();
        expect_q.delete();
        emit(enc_u(rv_pkg::OP_LUI, 5'd31, 20'h1));                  // x31 = 0x1000
        emit(enc_i(rv_pkg::OP_IMM, 3'b000, 5'd31, 5'd31, 12'h800)); // x31 = 0x800
    endfunction

    function automatic void fill_memories();
        // addi x0,x0,index in every word, a nop that differs per word
        foreach (imem[i]) imem[i] = enc_i(rv_pkg::OP_IMM, 3'b000, 5'd0, 5'd0, 12'(i));
        foreach (dmem[i]) dmem[i] = fill_word(64'(i * 8));
    endfunction

    task automatic report_test(input string name, input int bad);
        if (bad == 0) begin
            pass_count++;
            $display("%s: passed", name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", name, bad);
        end
    endtask

    task automatic test_reset();
        int bad;
        bad = 0;
        @(posedge clk_1hz);
        reset_n <= 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk_1hz);
            assert (o_imem_addr === RESET_PC && o_dmem_we === 1'b0) else begin
                $display("** Error: reset expected addr %h we 0 actual addr %h we %b",
                         RESET_PC, o_imem_addr, o_dmem_we);
                bad++;
            end
        end
        @(posedge clk_1hz);
        reset_n <= 1'b1;
        @(negedge clk_1hz);                           // first cycle out of reset
        assert (o_imem_addr === RESET_PC && o_dmem_we === 1'b0) else begin
            $display("** Error: reset release expected addr %h we 0 actual addr %h we %b",
                     RESET_PC, o_imem_addr, o_dmem_we);
            bad++;
        end
        report_test("reset", bad);
    endtask

    // resets the core, loads prog, waits for every expected store and compares
    task automatic run_program(input string name);
        int cycles;
        int bad;
        cycles = 0;
        bad = 0;
        emit(enc_j(5'd0, 21'd0));                     // park on a self loop
        @(posedge clk_1hz);
        reset_n <= 1'b0;
        @(posedge clk_1hz);
        fill_memories();
        foreach (prog[i]) imem[i] = prog[i];
        store_q.delete();
        repeat (RESET_CYCLES - 1) @(posedge clk_1hz);
        reset_n <= 1'b1;
        while (store_q.size() < expect_q.size() && cycles < WAIT_CYCLES) begin
            @(negedge clk_1hz);
            cycles++;
        end
        if (store_q.size() < expect_q.size()) begin
            $display("%s: only %0d of %0d result stores seen within %0d cycles",
                     name, store_q.size(), expect_q.size(), WAIT_CYCLES);
            bad++;
        end else begin
            foreach (expect_q[i]) begin
                assert (store_q[i] === expect_q[i]) else begin
                    $display("** Error: %s store %0d expected %h actual %h",
                             name, i, expect_q[i], store_q[i]);
                    bad++;
                end
            end
        end
        report_test(name, bad);
    endtask

    task automatic test_arith();
        logic [19:0]   u;
        logic [11:0]   a, b;
        rv_pkg::xlen_t auipc_pc;
        u = 20'(lfsr_bits(20));
        a = 12'(lfsr_bits(12));
        b = 12'(lfsr_bits(12));
        start_program();
        emit(enc_u(rv_pkg::OP_LUI, 5'd1, u));
        auipc_pc = pc_now();
        emit(enc_u(rv_pkg::OP_AUIPC, 5'd2, u));
        emit(enc_i(rv_pkg::OP_IMM, 3'b000, 5'd3, 5'd0, a));        // addi
        emit(enc_i(rv_pkg::OP_IMM, 3'b100, 5'd4, 5'd3, b));        // xori
        emit(enc_i(rv_pkg::OP_IMM, 3'b110, 5'd5, 5'd3, b));        // ori
        emit(enc_i(rv_pkg::OP_IMM, 3'b111, 5'd6, 5'd3, b));        // andi
        emit(enc_r(7'b0000000, 5'd7, 5'd1, 5'd3));                 // add
        emit(enc_r(7'b0100000, 5'd8, 5'd1, 5'd3));                 // sub
        emit(enc_i(rv_pkg::OP_IMM, 3'b000, 5'd0, 5'd0, a));        // x0 stays zero
        store_result(5'd1, upper(u));
        store_result(5'd2, auipc_pc + upper(u));
        store_result(5'd3, sx12(a));
        store_result(5'd4, sx12(a) ^ sx12(b));
        store_result(5'd5, sx12(a) | sx12(b));
        store_result(5'd6, sx12(a) & sx12(b));
        store_result(5'd7, upper(u) + sx12(a));
        store_result(5'd8, upper(u) - sx12(a));
        store_result(5'd0, 64'd0);
        run_program("arith");
    endtask

    task automatic test_memory();
        logic [19:0] u;
        logic [11:0] a;
        u = 20'(lfsr_bits(20));
        a = 12'(lfsr_bits(12));
        start_program();
        emit(enc_i(rv_pkg::OP_IMM, 3'b000, 5'd1, 5'd0, a));
        emit(enc_u(rv_pkg::OP_LUI, 5'd2, u));
        emit(enc_r(7'b0000000, 5'd3, 5'd1, 5'd2));                 // full 64 bit value
        emit(enc_i(rv_pkg::OP_IMM, 3'b000, 5'd4, 5'd0, 12'h100));  // buffer base
        emit(enc_s(5'd3, 5'd4, 12'd8));                            // sd x3,8(x4)
        emit(enc_i(rv_pkg::OP_LOAD, 3'b011, 5'd5, 5'd4, 12'd8));   // ld x5,8(x4)
        emit(enc_i(rv_pkg::OP_LOAD, 3'b011, 5'd6, 5'd4, 12'd16));  // untouched word
        store_result(5'd5, upper(u) + sx12(a));
        store_result(5'd6, fill_word(64'h110));
        run_program("memory");
    endtask

    task automatic test_control();
        rv_pkg::xlen_t jal_pc;
        start_program();
        emit(enc_i(rv_pkg::OP_IMM, 3'b000, 5'd1, 5'd0, 12'd7));    // marker
        emit(enc_i(rv_pkg::OP_IMM, 3'b000, 5'd2, 5'd0, 12'd7));
        emit(enc_b(3'b000, 5'd1, 5'd2, 13'd8));                    // beq taken
        emit(enc_i(rv_pkg::OP_IMM, 3'b000, 5'd1, 5'd0, 12'd99));   // must be skipped
        emit(enc_b(3'b001, 5'd1, 5'd2, 13'd8));                    // bne not taken
        emit(enc_i(rv_pkg::OP_IMM, 3'b000, 5'd3, 5'd0, 12'd5));    // fall through path
        jal_pc = pc_now();
        emit(enc_j(5'd4, 21'd8));
        emit(enc_i(rv_pkg::OP_IMM, 3'b000, 5'd1, 5'd0, 12'd55));   // skipped by jal
        store_result(5'd1, 64'd7);
        store_result(5'd3, 64'd5);
        store_result(5'd4, jal_pc + 64'd4);
        run_program("control");
    endtask

    task automatic test_csr();
        logic [11:0] a, b;
        a = 12'(lfsr_bits(12));
        b = 12'(lfsr_bits(12));
        start_program();
        emit(enc_i(rv_pkg::OP_IMM, 3'b000, 5'd1, 5'd0, a));
        emit(enc_i(rv_pkg::OP_SYSTEM, 3'b001, 5'd2, 5'd1, rv_pkg::CSR_MSCRATCH)); // csrrw
        emit(enc_i(rv_pkg::OP_IMM, 3'b000, 5'd3, 5'd0, b));
        emit(enc_i(rv_pkg::OP_SYSTEM, 3'b010, 5'd4, 5'd3, rv_pkg::CSR_MSCRATCH)); // csrrs
        emit(enc_i(rv_pkg::OP_SYSTEM, 3'b010, 5'd5, 5'd0, rv_pkg::CSR_MSCRATCH));
        emit(enc_i(rv_pkg::OP_SYSTEM, 3'b011, 5'd6, 5'd1, rv_pkg::CSR_MSCRATCH)); // csrrc
        emit(enc_i(rv_pkg::OP_SYSTEM, 3'b010, 5'd7, 5'd0, rv_pkg::CSR_MSCRATCH));
        emit(enc_i(rv_pkg::OP_SYSTEM, 3'b001, 5'd8, 5'd1, 12'h7c0));  // no such csr
        emit(enc_i(rv_pkg::OP_SYSTEM, 3'b010, 5'd9, 5'd0, 12'h7c0));
        store_result(5'd2, 64'd0);
        store_result(5'd4, sx12(a));
        store_result(5'd5, sx12(a) | sx12(b));
        store_result(5'd6, sx12(a) | sx12(b));
        store_result(5'd7, (sx12(a) | sx12(b)) & ~sx12(a));
        store_result(5'd8, 64'd0);
        store_result(5'd9, 64'd0);
        run_program("csr");
    endtask

    task automatic test_trap();
        logic [11:0]   m;
        rv_pkg::xlen_t ecall_pc;
        m = 12'(lfsr_bits(12));
        start_program();
        emit(enc_i(rv_pkg::OP_IMM, 3'b000, 5'd1, 5'd0, 12'd32));  // handler at word 8
        emit(enc_i(rv_pkg::OP_SYSTEM, 3'b001, 5'd0, 5'd1, rv_pkg::CSR_MTVEC));
        emit(enc_i(rv_pkg::OP_IMM, 3'b000, 5'd2, 5'd0, m));
        ecall_pc = pc_now();
        emit(enc_i(rv_pkg::OP_SYSTEM, 3'b000, 5'd0, 5'd0, 12'h000));  // ecall
        emit(enc_s(5'd2, 5'd31, 12'd0));             // marker, after mret
        emit(enc_j(5'd0, 21'd0));
        // handler, word 8
        emit(enc_i(rv_pkg::OP_SYSTEM, 3'b010, 5'd3, 5'd0, rv_pkg::CSR_MCAUSE));
        emit(enc_s(5'd3, 5'd31, 12'd0));
        emit(enc_i(rv_pkg::OP_SYSTEM, 3'b010, 5'd4, 5'd0, rv_pkg::CSR_MEPC));
        emit(enc_s(5'd4, 5'd31, 12'd0));
        emit(enc_i(rv_pkg::OP_IMM, 3'b000, 5'd4, 5'd4, 12'd4));   // step past ecall
        emit(enc_i(rv_pkg::OP_SYSTEM, 3'b001, 5'd0, 5'd4, rv_pkg::CSR_MEPC));
        emit(enc_i(rv_pkg::OP_SYSTEM, 3'b000, 5'd0, 5'd0, 12'h302));  // mret
        expect_q.push_back(64'd11);
        expect_q.push_back(ecall_pc);
        expect_q.push_back(sx12(m));
        run_program("trap");
    endtask

    initial begin
        reset_n = 1'b0;
        fill_memories();
        test_reset();
        test_arith();
        test_memory();
        test_control();
        test_csr();
        test_trap();
        $display("summary: %0d tests, %0d passed, %0d failed, %0d assertion failures",
                 pass_count + fail_count, pass_count, fail_count, DUT.u_cpu_assertions.fails);
        if (fail_count == 0 && DUT.u_cpu_assertions.fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- rv64_two_stage.f
common/rv_pkg.sv
common/fetch_exec_if.sv
common/csr_bus_if.sv
rtl/fetch_stage.sv
execute/reg_file.sv
execute/execute_stage.sv
rtl/csr_file.sv
rtl/cpu_top.sv
testbench/cpu_assertions.sv
testbench/tb_cpu_top.sv
